// ==== verilog.f ====
hdl/core_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/stage_reg.sv
hdl/exec_unit.sv
hdl/exec_pipe.sv
verification/exec_pipe_tb.sv

// ==== Makefile ====
TOP := exec_pipe_tb

simulate:
	verilator --binary -j 0 --timescale 1ns/100ps --top-module $(TOP) -f verilog.f -o sim
	./obj_dir/sim | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: simulate clean

// ==== verification/exec_pipe_tb.sv ====
`default_nettype none

module exec_pipe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic        illegal;
    logic        wena;
    logic [4:0]  rd;
    logic [31:0] result;
    logic [31:0] pc;
  } expect_t;

  localparam int num_random = 300;
  // reset, idle start, directed, random with idle slots, two drains
  localparam int stim_cycles = 5 + 4 + 30 + 2 * num_random + 80;
  localparam int timeout_limit = 8 * stim_cycles;

  logic        clock;
  logic        reset;
  logic        inst_valid_i;
  logic        inst_ready_o;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        wb_valid_o;
  logic        wb_ready_i;
  logic        wb_illegal_o;
  logic        wb_wena_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_result_o;
  logic [31:0] wb_pc_o;

  logic [31:0] lfsr_state;
  logic [31:0] model_regs [0:31];
  logic [31:0] next_pc;
  expect_t     exp_q [$];
  expect_t     cmp_rec;
  string       test_name;
  int          error_count = 0;
  int          missing_count = 0;
  int          accept_count = 0;
  int          retire_count = 0;
  int          cycle_count = 0;

  exec_pipe dut (.*);

  always #5 clock = ~clock;

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    bits = 32'h0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return bits;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // rv32i integer semantics by funct3, alt picks sub / sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // executes one accepted instruction on the model registers
  function automatic expect_t ref_exec(input logic [31:0] inst, input logic [31:0] pc);
    expect_t     e;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_u;
    f7 = inst[31:25];
    f3 = inst[14:12];
    a = model_regs[inst[19:15]];
    b = model_regs[inst[24:20]];
    imm_u = {inst[31:12], 12'h000};
    e.illegal = 1'b0;
    e.wena = 1'b1;
    e.rd = inst[11:7];
    e.pc = pc;
    e.result = 32'h0;
    case (inst[6:0])
      7'b0110011: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          e.result = alu_ref(f3, f7[5], a, b);
        end else begin
          e.illegal = 1'b1;
        end
      end
      7'b0010011: e.result = alu_ref(f3, f3 == 3'd5 && f7[5], a, {{20{inst[31]}}, inst[31:20]});
      7'b0110111: e.result = imm_u;
      7'b0010111: e.result = pc + imm_u;
      default:    e.illegal = 1'b1;
    endcase
    if (e.illegal) begin
      e.wena = 1'b0;
    end else if (e.rd != 5'd0) begin
      model_regs[e.rd] = e.result;
    end
    return e;
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] kind;
    logic [31:0] regs;
    logic [31:0] bits;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] inst;
    kind = lfsr_bits(3);
    // x0..x7 only, so dependencies are frequent
    regs = lfsr_bits(9);
    rd = {2'b00, regs[2:0]};
    rs1 = {2'b00, regs[5:3]};
    rs2 = {2'b00, regs[8:6]};
    bits = lfsr_bits(3);
    f3 = bits[2:0];
    case (kind[2:0])
      3'd0, 3'd1, 3'd2: begin
        bits = lfsr_bits(2);
        if (bits[1:0] == 2'd3) begin
          bits = lfsr_bits(7);
          f7 = bits[6:0];
        end else begin
          f7 = bits[1] ? 7'h20 : 7'h00;
        end
        inst = r_type(f7, rs2, rs1, f3, rd);
      end
      3'd3, 3'd4: begin
        bits = lfsr_bits(12);
        if (f3 == 3'd1) begin
          bits[11:5] = 7'h00;
        end else if (f3 == 3'd5) begin
          bits[11:5] = {1'b0, bits[10], 5'b0};
        end
        inst = i_type(bits[11:0], rs1, f3, rd);
      end
      3'd5, 3'd6: begin
        bits = lfsr_bits(20);
        inst = u_type(bits[19:0], rd, kind[0] ? 7'b0110111 : 7'b0010111);
      end
      default: begin
        // load, store, madd or branch opcode
        bits = lfsr_bits(27);
        inst = {bits[26:2], bits[1:0], 5'b00011};
      end
    endcase
    return inst;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  // one input slot, held until accepted when valid
  task automatic offer(input logic valid, input logic [31:0] inst);
    logic done;
    done = 1'b0;
    while (!done) begin
      inst_valid_i = valid;
      inst_i = inst;
      pc_i = next_pc;
      wb_ready_i = lfsr_bits(2) != 32'd0;
      @(posedge clock);
      if (inst_valid_i && inst_ready_o) begin
        exp_q.push_back(ref_exec(inst_i, pc_i));
        accept_count++;
        next_pc = next_pc + 32'd4;
      end
      done = !valid || (inst_valid_i && inst_ready_o);
      #1;
    end
  endtask

  task automatic drain_pipe();
    repeat (40) begin
      if (exp_q.size() != 0) begin
        offer(1'b0, 32'h0);
      end
    end
  endtask

  always @(negedge clock) begin
    if (!reset) begin
      check_value("inst_ready", 32'(wb_ready_i), 32'(inst_ready_o));
      if (accept_count == 0) begin
        check_value("wb_valid_idle", 32'd0, 32'(wb_valid_o));
      end
      // handshake seen here completes at the next rising edge
      if (wb_valid_o && wb_ready_i) begin
        retire_count++;
        if (exp_q.size() == 0) begin
          $display("an unexpected result retired with pc %h", wb_pc_o);
          error_count++;
        end else begin
          cmp_rec = exp_q.pop_front();
          check_value("pc", cmp_rec.pc, wb_pc_o);
          check_value("illegal", 32'(cmp_rec.illegal), 32'(wb_illegal_o));
          check_value("wena", 32'(cmp_rec.wena), 32'(wb_wena_o));
          check_value("rd", 32'(cmp_rec.rd), 32'(wb_rd_o));
          check_value("result", cmp_rec.result, wb_result_o);
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("timeout, the run did not finish within %0d cycles", timeout_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    inst_valid_i = 1'b0;
    inst_i = 32'h0;
    pc_i = 32'h0;
    wb_ready_i = 1'b1;
    lfsr_state = 32'd98;
    next_pc = 32'h0000_1000;
    test_name = "reset";
    foreach (model_regs[r]) begin
      model_regs[r] = 32'h0;
    end
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (4) offer(1'b0, 32'h0);

    test_name = "directed";
    offer(1'b1, u_type(20'hF0000, 5'd1, 7'b0110111));
    offer(1'b1, i_type(12'h123, 5'd1, 3'd0, 5'd1));
    offer(1'b1, i_type(12'h005, 5'd0, 3'd0, 5'd2));
    // x1 at distance two, x2 at distance one
    offer(1'b1, r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
    offer(1'b1, i_type(12'h404, 5'd1, 3'd5, 5'd4));
    offer(1'b1, r_type(7'h00, 5'd2, 5'd1, 3'd5, 5'd5));
    offer(1'b1, r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd6));
    offer(1'b1, r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd7));
    offer(1'b1, i_type(12'hFFF, 5'd1, 3'd2, 5'd6));
    offer(1'b1, i_type(12'hFFF, 5'd2, 3'd3, 5'd7));
    offer(1'b1, r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
    offer(1'b1, r_type(7'h00, 5'd2, 5'd1, 3'd1, 5'd4));
    offer(1'b1, r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd5));
    offer(1'b1, r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd6));
    offer(1'b1, r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd7));
    offer(1'b1, i_type(12'h01F, 5'd1, 3'd1, 5'd3));
    offer(1'b1, u_type(20'h12345, 5'd5, 7'b0010111));
    // write to x0, then read it back at distance one and two
    offer(1'b1, i_type(12'h007, 5'd1, 3'd0, 5'd0));
    offer(1'b1, r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd3));
    offer(1'b1, r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd4));
    // lw x1, then two bad OP encodings, none may touch x1
    offer(1'b1, 32'h0000_2083);
    offer(1'b1, r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd1));
    offer(1'b1, r_type(7'h20, 5'd2, 5'd1, 3'd4, 5'd1));
    offer(1'b1, r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd5));
    drain_pipe();

    test_name = "random";
    repeat (num_random) begin
      if (lfsr_bits(2) == 32'd0) begin
        offer(1'b0, 32'h0);
      end
      offer(1'b1, random_inst());
    end
    drain_pipe();

    if (exp_q.size() != 0) begin
      missing_count = exp_q.size();
      $display("%0d expected results never retired", missing_count);
    end
    $display("accepted %0d, retired %0d, errors %0d", accept_count, retire_count,
             error_count + missing_count);
    if (error_count + missing_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/exec_pipe.sv ====
`default_nettype none

module exec_pipe (
  input  logic        clock,
  input  logic        reset,
  input  logic        inst_valid_i,
  output logic        inst_ready_o,
  input  logic [31:0] inst_i,
  input  logic [31:0] pc_i,
  output logic        wb_valid_o,
  input  logic        wb_ready_i,
  output logic        wb_illegal_o,
  output logic        wb_wena_o,
  output logic [4:0]  wb_rd_o,
  output logic [31:0] wb_result_o,
  output logic [31:0] wb_pc_o
);

  import core_pkg::*;

  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        rf_we;
  id_ex_t      decoded;
  id_ex_t      id_ex_d;
  id_ex_t      id_ex_q;
  ex_wb_t      ex_wb_d;
  ex_wb_t      ex_wb_q;

  // whole pipeline advances or stalls together
  assign inst_ready_o = wb_ready_i;

  inst_decoder u_decoder (
    .inst_i     (inst_i),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .decoded_o  (decoded)
  );

  reg_file u_reg_file (
    .clock      (clock),
    .reset      (reset),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_i       (ex_wb_q.rd),
    .wdata_i    (ex_wb_q.result)
  );

  // bubble when no instruction is offered
  always_comb begin
    id_ex_d       = decoded;
    id_ex_d.valid = inst_valid_i;
  end

  stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clock  (clock),
    .reset  (reset),
    .load_i (wb_ready_i),
    .d_i    (id_ex_d),
    .q_o    (id_ex_q)
  );

  exec_unit u_exec_unit (
    .id_ex_i (id_ex_q),
    .ex_wb_i (ex_wb_q),
    .ex_wb_o (ex_wb_d)
  );

  stage_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
    .clock  (clock),
    .reset  (reset),
    .load_i (wb_ready_i),
    .d_i    (ex_wb_d),
    .q_o    (ex_wb_q)
  );

  // write at the retiring edge only
  assign rf_we = ex_wb_q.valid && ex_wb_q.wena && wb_ready_i;

  assign wb_valid_o   = ex_wb_q.valid;
  assign wb_illegal_o = ex_wb_q.illegal;
  assign wb_wena_o    = ex_wb_q.wena;
  assign wb_rd_o      = ex_wb_q.rd;
  assign wb_result_o  = ex_wb_q.result;
  assign wb_pc_o      = ex_wb_q.pc;

endmodule

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`default_nettype none

module exec_unit (
  input  core_pkg::id_ex_t id_ex_i,
  input  core_pkg::ex_wb_t ex_wb_i,
  output core_pkg::ex_wb_t ex_wb_o
);

  import core_pkg::*;

  logic        wb_hit;
  logic        fwd_rs1;
  logic        fwd_rs2;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shamt;
  logic [31:0] alu_result;

  // older instruction in writeback that writes a real register
  assign wb_hit  = ex_wb_i.valid && ex_wb_i.wena && ex_wb_i.rd != 5'd0;
  assign fwd_rs1 = wb_hit && ex_wb_i.rd == id_ex_i.rs1_addr;
  assign fwd_rs2 = wb_hit && ex_wb_i.rd == id_ex_i.rs2_addr;

  assign rs1_val = fwd_rs1 ? ex_wb_i.result : id_ex_i.rs1_data;
  assign rs2_val = fwd_rs2 ? ex_wb_i.result : id_ex_i.rs2_data;

  always_comb begin
    case (id_ex_i.src_a)
      SRC_A_PC:   op_a = id_ex_i.pc;
      SRC_A_ZERO: op_a = '0;
      default:    op_a = rs1_val;
    endcase
  end

  assign op_b  = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  always_comb begin
    ex_wb_o.valid   = id_ex_i.valid;
    ex_wb_o.illegal = id_ex_i.illegal;
    ex_wb_o.wena    = id_ex_i.wena;
    ex_wb_o.rd      = id_ex_i.rd;
    ex_wb_o.pc      = id_ex_i.pc;
    ex_wb_o.result  = id_ex_i.illegal ? 32'b0 : alu_result;
  end

endmodule

`default_nettype wire

// ==== hdl/stage_reg.sv ====
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     load_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // empty payload after reset, held while load is low
  always_ff @(posedge clock) begin
    if (reset) begin
      q_o <= '0;
    end else if (load_i) begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1_addr_i,
  input  logic [4:0]  rs2_addr_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o,
  input  logic        we_i,
  input  logic [4:0]  rd_i,
  input  logic [31:0] wdata_i
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  function automatic logic [31:0] read_reg(input logic [4:0] addr);
    logic [31:0] data;
    if (addr == 5'd0) begin
      data = '0;
    end else if (we_i && rd_i == addr) begin
      // write-through for the retiring instruction
      data = wdata_i;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    rs1_data_o = read_reg(rs1_addr_i);
    rs2_data_o = read_reg(rs2_addr_i);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
  input  logic [31:0]      inst_i,
  input  logic [31:0]      pc_i,
  input  logic [31:0]      rs1_data_i,
  input  logic [31:0]      rs2_data_i,
  output logic [4:0]       rs1_addr_o,
  output logic [4:0]       rs2_addr_o,
  output core_pkg::id_ex_t decoded_o
);

  import core_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i_type;
  logic [31:0] imm_u_type;

  // alt selects sub / sra where funct3 alone is ambiguous
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u_type = {inst_i[31:12], 12'b0};

  always_comb begin
    decoded_o          = '0;
    decoded_o.valid    = 1'b1;
    decoded_o.rs1_addr = rs1_addr_o;
    decoded_o.rs2_addr = rs2_addr_o;
    decoded_o.rd       = inst_i[11:7];
    decoded_o.rs1_data = rs1_data_i;
    decoded_o.rs2_data = rs2_data_i;
    decoded_o.pc       = pc_i;
    decoded_o.src_a    = SRC_A_RS1;
    decoded_o.alu_op   = ALU_ADD;

    case (opcode)
      OPC_OP: begin
        decoded_o.alu_op = alu_from_funct3(funct3, funct7[5]);
        if (funct7 == 7'b0000000) begin
          decoded_o.wena = 1'b1;
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          decoded_o.wena = 1'b1;
        end else begin
          decoded_o.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        // no subi, so bit 30 only matters for the right shift
        decoded_o.alu_op  = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
        decoded_o.use_imm = 1'b1;
        decoded_o.imm     = imm_i_type;
        decoded_o.wena    = 1'b1;
      end
      OPC_LUI: begin
        decoded_o.alu_op  = ALU_PASS_B;
        decoded_o.src_a   = SRC_A_ZERO;
        decoded_o.use_imm = 1'b1;
        decoded_o.imm     = imm_u_type;
        decoded_o.wena    = 1'b1;
      end
      OPC_AUIPC: begin
        decoded_o.src_a   = SRC_A_PC;
        decoded_o.use_imm = 1'b1;
        decoded_o.imm     = imm_u_type;
        decoded_o.wena    = 1'b1;
      end
      default: begin
        decoded_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // major opcodes handled by this slice
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // operand a source
  typedef enum logic [1:0] {
    SRC_A_RS1,
    SRC_A_PC,
    SRC_A_ZERO
  } src_a_e;

  typedef struct packed {
    logic        valid;
    logic        illegal;
    logic        wena;
    alu_op_e     alu_op;
    src_a_e      src_a;
    logic        use_imm;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [31:0] pc;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    logic        illegal;
    logic        wena;
    logic [4:0]  rd;
    logic [31:0] result;
    logic [31:0] pc;
  } ex_wb_t;

endpackage

`default_nettype wire
